//--- filelist.f
+incdir+.
ooo_pkg.sv
inst_decoder.sv
exec_pipe.sv
reorder_buffer.sv
ooo_core_top.sv
ooo_core_properties.sv
tb_ooo_core.sv

//--- Makefile
SIM_LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_ooo_core \
		-f filelist.f -o sim_tb
	./obj_dir/sim_tb > $(SIM_LOG) 2>&1 || true
	@cat $(SIM_LOG)
	@grep -q "Simulation finished: PASS" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)

//--- tb_ooo_core.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module tb_ooo_core;

    localparam int N_BURST = 20;
    localparam logic [1:0] OUT_COMMIT = 2'd0;
    localparam logic [1:0] OUT_KILLED = 2'd1;
    localparam logic [1:0] OUT_FLUSH  = 2'd2;
    localparam logic [1:0] OUT_EXC    = 2'd3;

    typedef struct packed {
        ooo_pkg::word_t inst;
        ooo_pkg::word_t rs;
        ooo_pkg::word_t rt;
        logic           pred;
        logic [3:0]     idle;     // idle cycles after the row
        logic [1:0]     outcome;
    } row_t;

    typedef struct packed {
        logic [1:0]       kind;
        ooo_pkg::commit_t c;
        int               due;    // negative when the cycle is not fixed
    } evt_t;

    logic             clk = 1'b0;
    logic             rst;
    logic             inst_valid;
    ooo_pkg::word_t   inst;
    ooo_pkg::word_t   rs_val;
    ooo_pkg::word_t   rt_val;
    logic             pred;
    logic             commit_stall;
    logic             stall;
    logic             commit_valid;
    ooo_pkg::commit_t commit;
    logic             flush;
    logic             exception;

    row_t table_rows[$];
    evt_t expq[$];
    int   cycle = 0;
    int   timeout_limit = 100000;
    int   seed;
    int   burst_accepted;

    ooo_core_top dut0 (
        .clk(clk), .rst(rst), .inst_valid(inst_valid), .inst(inst), .rs_val(rs_val),
        .rt_val(rt_val), .pred(pred), .commit_stall(commit_stall), .stall(stall),
        .commit_valid(commit_valid), .commit(commit), .flush(flush), .exception(exception)
    );

    always #4 clk = ~clk;

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_commit(input ooo_pkg::commit_t got, input ooo_pkg::commit_t exp);
        if (got.op !== exp.op)
            fail_now($sformatf("ERR commit.op got %h exp %h", got.op, exp.op));
        if (got.rd !== exp.rd)
            fail_now($sformatf("ERR commit.rd got %h exp %h", got.rd, exp.rd));
        // a load carries no data, memory is read outside the core
        if (exp.op != `OP_LW && got.data !== exp.data)
            fail_now($sformatf("ERR commit.data got %h exp %h", got.data, exp.data));
        if ((exp.op == `OP_LW || exp.op == `OP_SW) && got.addr !== exp.addr)
            fail_now($sformatf("ERR commit.addr got %h exp %h", got.addr, exp.addr));
    endtask

    task automatic check_ctrl(input ooo_pkg::commit_ctrl_t got, input ooo_pkg::commit_ctrl_t exp);
        if (got !== exp)
            fail_now($sformatf("ERR commit.ctrl got %h exp %h", got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_now($sformatf("ERR %s got %h exp %h", name, got, exp));
    endtask

    function automatic ooo_pkg::word_t rtype(ooo_pkg::reg_idx_t rd, logic [5:0] fn);
        return {`OPC_RTYPE, 5'd1, 5'd2, rd, 5'd0, fn};
    endfunction

    function automatic ooo_pkg::word_t itype(logic [5:0] opc, ooo_pkg::reg_idx_t rt,
                                             logic [15:0] imm);
        return {opc, 5'd1, rt, imm};
    endfunction

    // expected retirement record worked out from the instruction fields
    function automatic ooo_pkg::commit_t expect_commit(row_t r);
        ooo_pkg::commit_t c;
        logic [5:0]       opc;
        ooo_pkg::word_t   imm;
        c   = '0;
        opc = r.inst[31:26];
        imm = {{16{r.inst[15]}}, r.inst[15:0]};
        if (opc == `OPC_RTYPE) begin
            c.rd   = r.inst[15:11];
            c.ctrl = 3'b100;
            case (r.inst[5:0])
                `FN_ADD: begin
                    c.op   = `OP_ADD;
                    c.data = r.rs + r.rt;
                end
                `FN_SUB: begin
                    c.op   = `OP_SUB;
                    c.data = r.rs - r.rt;
                end
                `FN_AND: begin
                    c.op   = `OP_AND;
                    c.data = r.rs & r.rt;
                end
                `FN_OR: begin
                    c.op   = `OP_OR;
                    c.data = r.rs | r.rt;
                end
                default: begin
                    c.op   = `OP_SLT;
                    c.data = ($signed(r.rs) < $signed(r.rt)) ? 1 : 0;
                end
            endcase
        end else if (opc == `OPC_LW) begin
            c.op   = `OP_LW;
            c.rd   = r.inst[20:16];
            c.addr = r.rs + imm;
            c.ctrl = 3'b110;
        end else if (opc == `OPC_SW) begin
            c.op   = `OP_SW;
            c.addr = r.rs + imm;
            c.data = r.rt;
            c.ctrl = 3'b001;
        end else begin
            c.op = (opc == `OPC_BEQ) ? `OP_BEQ : `OP_BNE; // a correct branch retires with ctrl zero
        end
        return c;
    endfunction

    task automatic add_row(input ooo_pkg::word_t i, input ooo_pkg::word_t a,
                           input ooo_pkg::word_t b, input logic p, input int idle,
                           input logic [1:0] outc);
        table_rows.push_back('{inst: i, rs: a, rt: b, pred: p, idle: idle[3:0], outcome: outc});
    endtask

    task automatic build_table();
        add_row(rtype(5'd3, `FN_ADD), 32'd5, 32'd7, 1'b0, 0, OUT_COMMIT);
        add_row(rtype(5'd4, `FN_SUB), 32'd10, 32'd3, 1'b0, 0, OUT_COMMIT);
        add_row(rtype(5'd5, `FN_AND), 32'h0000f0f0, 32'h0000ff00, 1'b0, 0, OUT_COMMIT);
        add_row(rtype(5'd6, `FN_OR), 32'h0000f0f0, 32'h00000f0f, 1'b0, 0, OUT_COMMIT);
        add_row(rtype(5'd7, `FN_SLT), 32'hffffffff, 32'd2, 1'b0, 2, OUT_COMMIT);
        add_row(itype(`OPC_LW, 5'd8, 16'h0010), 32'h00001000, 32'd0, 1'b0, 0, OUT_COMMIT);
        add_row(itype(`OPC_LW, 5'd9, 16'hfffc), 32'h00002000, 32'd0, 1'b0, 0, OUT_COMMIT);
        add_row(itype(`OPC_SW, 5'd10, 16'h0004), 32'h00003000, 32'hdeadbeef, 1'b0, 2, OUT_COMMIT);
        add_row(itype(`OPC_BEQ, 5'd2, 16'h0008), 32'd7, 32'd7, 1'b1, 0, OUT_COMMIT);
        add_row(itype(`OPC_BNE, 5'd2, 16'h0008), 32'd1, 32'd2, 1'b1, 0, OUT_COMMIT);
        add_row(itype(`OPC_BEQ, 5'd2, 16'h0008), 32'd1, 32'd2, 1'b0, 2, OUT_COMMIT);
        add_row(itype(`OPC_BEQ, 5'd2, 16'h0008), 32'd9, 32'd9, 1'b0, 0, OUT_FLUSH);
        add_row(rtype(5'd11, `FN_ADD), 32'd1, 32'd1, 1'b0, 0, OUT_KILLED);
        add_row(rtype(5'd12, `FN_ADD), 32'd2, 32'd2, 1'b0, 0, OUT_KILLED);
        add_row(rtype(5'd13, `FN_ADD), 32'd3, 32'd3, 1'b0, 2, OUT_COMMIT);
        add_row(itype(`OPC_BNE, 5'd2, 16'h0008), 32'd4, 32'd4, 1'b1, 0, OUT_FLUSH);
        add_row(itype(`OPC_SW, 5'd2, 16'h0000), 32'd4, 32'd4, 1'b0, 0, OUT_KILLED);
        add_row(itype(`OPC_LW, 5'd14, 16'h0000), 32'd4, 32'd4, 1'b0, 0, OUT_KILLED);
        add_row(rtype(5'd15, `FN_OR), 32'h00ff0000, 32'h000000ff, 1'b0, 2, OUT_COMMIT);
        add_row(rtype(5'd16, `FN_ADD), 32'h7fffffff, 32'd1, 1'b0, 0, OUT_EXC);
        add_row(rtype(5'd17, `FN_ADD), 32'd5, 32'd5, 1'b0, 0, OUT_KILLED);
        add_row(rtype(5'd18, `FN_SUB), 32'd5, 32'd5, 1'b0, 0, OUT_KILLED);
        add_row(rtype(5'd19, `FN_SUB), 32'd20, 32'd50, 1'b0, 2, OUT_COMMIT);
        add_row(32'hfc000000, 32'd0, 32'd0, 1'b0, 0, OUT_EXC);  // opcode 0x3f is not supported
        add_row(itype(`OPC_LW, 5'd20, 16'h0020), 32'd8, 32'd0, 1'b0, 0, OUT_KILLED);
        add_row(itype(`OPC_SW, 5'd2, 16'h0020), 32'd8, 32'd1, 1'b0, 0, OUT_KILLED);
        add_row(rtype(5'd21, `FN_SLT), 32'd3, 32'hfffffff0, 1'b0, 6, OUT_COMMIT);
    endtask

    // holds the row on the inputs until an edge accepts it, returns that edge's count
    task automatic offer(input row_t r, input logic burst, output int acc_cycle);
        logic ok;
        int   held;
        held       = 0;
        inst_valid = 1'b1;
        inst       = r.inst;
        rs_val     = r.rs;
        rt_val     = r.rt;
        pred       = r.pred;
        do begin
            #6;
            ok = !stall;
            if (!ok && burst && commit_stall) begin
                if (held == 0 && burst_accepted != `ROB_DEPTH)
                    fail_now($sformatf("stall rose after %0d adds instead of %0d",
                                       burst_accepted, `ROB_DEPTH));
                held++;
            end
            @(posedge clk);
            #1;
            if (held == 3)
                commit_stall = 1'b0; // release retirement once stall has been seen a while
        end while (!ok);
        acc_cycle  = cycle;
        inst_valid = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > timeout_limit) begin
            $display("timeout after %0d cycles, %0d results never arrived", cycle, expq.size());
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    // outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        evt_t e;
        if (!rst && (commit_valid || flush || exception)) begin
            if (expq.size() == 0)
                fail_now("a retirement, flush or exception appeared when none was expected");
            e = expq.pop_front();
            check_flag("commit_valid", commit_valid, e.kind == OUT_COMMIT);
            check_flag("flush", flush, e.kind == OUT_FLUSH);
            check_flag("exception", exception, e.kind == OUT_EXC);
            if (e.kind == OUT_COMMIT) begin
                check_commit(commit, e.c);
                check_ctrl(commit.ctrl, e.c.ctrl);
            end
            if (e.due >= 0 && cycle != e.due)
                fail_now($sformatf("result arrived in cycle %0d instead of cycle %0d",
                                   cycle, e.due));
        end
    end

    initial begin
        row_t r;
        int   acc;
        rst          = 1'b1;
        inst_valid   = 1'b0;
        inst         = '0;
        rs_val       = '0;
        rt_val       = '0;
        pred         = 1'b0;
        commit_stall = 1'b0;
        seed         = 2568;
        burst_accepted = 0;
        build_table();
        timeout_limit = (table_rows.size() + N_BURST) * 8 + 200;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        check_flag("stall", stall, 1'b0);
        check_flag("commit_valid", commit_valid, 1'b0);
        check_flag("flush", flush, 1'b0);
        check_flag("exception", exception, 1'b0);

        foreach (table_rows[i]) begin
            r = table_rows[i];
            offer(r, 1'b0, acc);
            if (r.outcome != OUT_KILLED)
                expq.push_back('{kind: r.outcome, c: expect_commit(r), due: acc + 3});
            repeat (r.idle) begin
                @(posedge clk);
                #1;
            end
        end
        while (expq.size() > 0) @(posedge clk);
        #1;

        // back-pressure burst, retirement blocked until stall has risen
        commit_stall = 1'b1;
        for (int k = 0; k < N_BURST; k++) begin
            r.rs      = $random(seed) & 32'h3fffffff;  // small enough that no sum overflows
            r.rt      = $random(seed) & 32'h3fffffff;
            r.inst    = rtype(5'($random(seed)), `FN_ADD);
            r.pred    = 1'b0;
            r.idle    = '0;
            r.outcome = OUT_COMMIT;
            expq.push_back('{kind: OUT_COMMIT, c: expect_commit(r), due: -1});
            offer(r, 1'b1, acc);
            burst_accepted++;
        end
        if (commit_stall)
            fail_now("stall never rose during the back-pressure burst");
        while (expq.size() > 0) @(posedge clk);
        repeat (4) @(posedge clk);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- ooo_core_properties.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module ooo_core_properties (
    input logic                  clk,
    input logic                  rst,
    input logic                  commit_valid,
    input logic                  flush,
    input logic                  exception,
    input logic                  stall,
    input logic                  kill,
    input logic [`ROB_DEPTH-1:0] busy
);

    // a retirement, a flush and an exception are mutually exclusive outcomes
    assert property (@(posedge clk) disable iff (rst)
        $onehot0({commit_valid, flush, exception}))
        else $error("commit_valid, flush and exception high together");

    assert property (@(posedge clk) disable iff (rst) (&busy) |-> stall)
        else $error("buffer full but stall is low");

    // the discard decided by kill shows up as flush or exception one cycle later
    assert property (@(posedge clk) disable iff (rst) kill |=> (flush || exception))
        else $error("kill not followed by flush or exception");

endmodule

bind reorder_buffer ooo_core_properties props0 (
    .clk(clk), .rst(rst), .commit_valid(commit_valid), .flush(flush),
    .exception(exception), .stall(stall), .kill(kill), .busy(busy)
);

//--- ooo_core_top.sv
`timescale 1ns/1ps

module ooo_core_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             inst_valid,
    input  ooo_pkg::word_t   inst,
    input  ooo_pkg::word_t   rs_val,
    input  ooo_pkg::word_t   rt_val,
    input  logic             pred,
    input  logic             commit_stall,
    output logic             stall,
    output logic             commit_valid,
    output ooo_pkg::commit_t commit,
    output logic             flush,
    output logic             exception
);

    ooo_pkg::uop_t        alloc;
    logic                 alloc_valid;
    ooo_pkg::rob_tag_t    alloc_tag;
    ooo_pkg::issue_t      issue;
    logic                 kill;     // head decided a flush or an exception
    ooo_pkg::addr_bcast_t addr_bcast;
    ooo_pkg::cdb_t        cdb;

    inst_decoder decode (
        .clk(clk), .rst(rst), .inst_valid(inst_valid), .inst(inst),
        .rs_val(rs_val), .rt_val(rt_val), .pred(pred), .stall(stall), .kill(kill),
        .alloc(alloc), .alloc_valid(alloc_valid), .alloc_tag(alloc_tag), .issue(issue)
    );

    exec_pipe execute (
        .clk(clk), .rst(rst), .issue(issue), .kill(kill),
        .addr_bcast(addr_bcast), .cdb(cdb)
    );

    reorder_buffer result (
        .clk(clk), .rst(rst), .alloc(alloc), .alloc_valid(alloc_valid),
        .alloc_tag(alloc_tag), .addr_bcast(addr_bcast), .cdb(cdb),
        .commit_stall(commit_stall), .stall(stall), .kill(kill),
        .commit_valid(commit_valid), .commit(commit), .flush(flush), .exception(exception)
    );

endmodule

//--- reorder_buffer.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module reorder_buffer (
    input  logic                 clk,
    input  logic                 rst,
    input  ooo_pkg::uop_t        alloc,
    input  logic                 alloc_valid,
    output ooo_pkg::rob_tag_t    alloc_tag,
    input  ooo_pkg::addr_bcast_t addr_bcast,
    input  ooo_pkg::cdb_t        cdb,
    input  logic                 commit_stall,
    output logic                 stall,
    output logic                 kill,
    output logic                 commit_valid,
    output ooo_pkg::commit_t     commit,
    output logic                 flush,
    output logic                 exception
);

    ooo_pkg::op_t      e_op   [`ROB_DEPTH];
    ooo_pkg::reg_idx_t e_rd   [`ROB_DEPTH];
    ooo_pkg::word_t    e_data [`ROB_DEPTH];
    ooo_pkg::word_t    e_addr [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] e_branch;
    logic [`ROB_DEPTH-1:0] e_pred;
    logic [`ROB_DEPTH-1:0] busy;
    logic [`ROB_DEPTH-1:0] ready;
    logic [`ROB_DEPTH-1:0] sec_evt;  // a store has seen one of its two beats
    logic [`ROB_DEPTH-1:0] misp;
    logic [`ROB_DEPTH-1:0] exc;

    ooo_pkg::rob_idx_t head;
    ooo_pkg::rob_idx_t tail;
    ooo_pkg::rob_idx_t cdb_idx;
    ooo_pkg::rob_idx_t addr_idx;
    logic              cdb_hit;
    logic              addr_hit;
    logic              head_hit;
    logic              head_ready;
    logic              head_misp;
    logic              head_exc;
    logic              decide;
    logic              do_commit;
    ooo_pkg::commit_t  commit_next;

    function automatic ooo_pkg::rob_idx_t tag_to_idx(ooo_pkg::rob_tag_t tag);
        ooo_pkg::rob_tag_t idx;
        idx = tag - 5'd1;
        return idx[3:0];
    endfunction

    function automatic ooo_pkg::commit_ctrl_t ctrl_of(ooo_pkg::op_t op);
        logic reg_wr;
        reg_wr = (op == `OP_ADD) || (op == `OP_SUB) || (op == `OP_AND) ||
                 (op == `OP_OR) || (op == `OP_SLT) || (op == `OP_LW);
        return {reg_wr, op == `OP_LW, op == `OP_SW};
    endfunction

    assign alloc_tag = {1'b0, tail} + 5'd1;

    assign cdb_idx  = tag_to_idx(cdb.tag);
    assign addr_idx = tag_to_idx(addr_bcast.tag);
    assign cdb_hit  = cdb.valid && (cdb.tag != '0) && busy[cdb_idx];
    assign addr_hit = addr_bcast.valid && (addr_bcast.tag != '0) && busy[addr_idx];

    // a bus beat for the head entry is seen in the same cycle it arrives,
    // so the head can retire or trigger at the edge that writes the beat
    assign head_hit   = cdb_hit && (cdb_idx == head);
    assign head_ready = ready[head] || (head_hit && (e_op[head] != `OP_SW || sec_evt[head]));
    assign head_misp  = (head_hit && e_branch[head]) ? (cdb.taken != e_pred[head]) : misp[head];
    assign head_exc   = exc[head] || (head_hit && cdb.ovf);

    assign decide    = busy[head] && head_ready && !commit_stall;
    assign kill      = decide && (head_exc || head_misp);
    assign do_commit = decide && !head_exc && !head_misp;

    assign stall = ((head == tail) && busy[head]) || kill; // full, or discarding this cycle

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head    <= '0;
            tail    <= '0;
            busy    <= '0;
            ready   <= '0;
            sec_evt <= '0;
            misp    <= '0;
            exc     <= '0;
        end else begin
            if (alloc_valid) begin
                busy[tail]    <= 1'b1;
                ready[tail]   <= 1'b0;
                sec_evt[tail] <= 1'b0;
                misp[tail]    <= 1'b0;
                exc[tail]     <= alloc.illegal; // raised once its pipeline beat readies it
                tail          <= tail + 4'd1;
            end
            if (addr_hit) begin
                if (e_op[addr_idx] == `OP_SW && !sec_evt[addr_idx]) begin
                    sec_evt[addr_idx] <= 1'b1;
                end else begin
                    ready[addr_idx] <= 1'b1;
                end
            end
            if (cdb_hit) begin
                if (e_op[cdb_idx] == `OP_SW && !sec_evt[cdb_idx]) begin
                    sec_evt[cdb_idx] <= 1'b1; // store still waits for its address
                end else begin
                    ready[cdb_idx] <= 1'b1;
                end
                if (e_branch[cdb_idx]) begin
                    misp[cdb_idx] <= (cdb.taken != e_pred[cdb_idx]);
                end
                if (cdb.ovf) begin
                    exc[cdb_idx] <= 1'b1;
                end
            end
            if (do_commit) begin
                busy[head] <= 1'b0;
                head       <= head + 4'd1;
            end
            if (kill) begin
                busy <= '0;   // every entry behind the head is younger
                head <= tail;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            e_op[tail]     <= alloc.op;
            e_rd[tail]     <= alloc.rd;
            e_pred[tail]   <= alloc.pred;
            e_branch[tail] <= (alloc.op == `OP_BEQ) || (alloc.op == `OP_BNE);
        end
        if (addr_hit) begin
            e_addr[addr_idx] <= addr_bcast.addr;
        end
        if (cdb_hit) begin
            e_data[cdb_idx] <= cdb.data;
        end
    end

    always_comb begin
        commit_next.op   = e_op[head];
        commit_next.rd   = e_rd[head];
        commit_next.data = head_hit ? cdb.data : e_data[head];
        commit_next.addr = e_addr[head];
        commit_next.ctrl = ctrl_of(e_op[head]); // a correct branch retires with all bits clear
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit_valid <= 1'b0;
            flush        <= 1'b0;
            exception    <= 1'b0;
        end else begin
            commit_valid <= do_commit;
            flush        <= kill && !head_exc;
            exception    <= kill && head_exc;
        end
    end

    always_ff @(posedge clk) begin
        if (do_commit) begin
            commit <= commit_next;
        end
    end

endmodule

//--- exec_pipe.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module exec_pipe (
    input  logic                   clk,
    input  logic                   rst,
    input  ooo_pkg::issue_t        issue,
    input  logic                   kill,
    output ooo_pkg::addr_bcast_t   addr_bcast,
    output ooo_pkg::cdb_t          cdb
);

    logic              s1_valid;
    ooo_pkg::rob_tag_t s1_tag;
    ooo_pkg::uop_t     s1_uop;
    ooo_pkg::word_t    sum;
    ooo_pkg::word_t    diff;
    ooo_pkg::word_t    mem_addr;
    ooo_pkg::word_t    result;
    logic              taken;
    logic              ovf;
    logic              s2_valid;
    ooo_pkg::rob_tag_t s2_tag;
    ooo_pkg::word_t    s2_data;
    logic              s2_taken;
    logic              s2_ovf;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (kill) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= issue.valid;
            s2_valid <= s1_valid && (s1_uop.op != `OP_LW); // loads finish on the address path
        end
    end

    always_ff @(posedge clk) begin
        s1_tag   <= issue.tag;
        s1_uop   <= issue.uop;
        s2_tag   <= s1_tag;
        s2_data  <= result;
        s2_taken <= taken;
        s2_ovf   <= ovf;
    end

    assign sum      = s1_uop.rs_val + s1_uop.rt_val;
    assign diff     = s1_uop.rs_val - s1_uop.rt_val;
    assign mem_addr = s1_uop.rs_val + s1_uop.imm;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        ovf    = 1'b0;
        case (s1_uop.op)
            `OP_ADD: begin
                result = sum;
                // operands agree in sign but the sum does not
                ovf = (s1_uop.rs_val[31] == s1_uop.rt_val[31]) && (sum[31] != s1_uop.rs_val[31]);
            end
            `OP_SUB: begin
                result = diff;
                ovf = (s1_uop.rs_val[31] != s1_uop.rt_val[31]) && (diff[31] != s1_uop.rs_val[31]);
            end
            `OP_AND: result = s1_uop.rs_val & s1_uop.rt_val;
            `OP_OR:  result = s1_uop.rs_val | s1_uop.rt_val;
            `OP_SLT: result = {31'd0, $signed(s1_uop.rs_val) < $signed(s1_uop.rt_val)};
            `OP_SW:  result = s1_uop.rt_val;              // store data rides the bus
            `OP_BEQ: taken = (s1_uop.rs_val == s1_uop.rt_val);
            `OP_BNE: taken = (s1_uop.rs_val != s1_uop.rt_val);
            default: result = '0;
        endcase
    end

    assign addr_bcast = '{valid: s1_valid && (s1_uop.op == `OP_LW || s1_uop.op == `OP_SW),
                          tag: s1_tag, addr: mem_addr};

    assign cdb = '{valid: s2_valid, tag: s2_tag, data: s2_data, taken: s2_taken, ovf: s2_ovf};

endmodule

//--- inst_decoder.sv
`timescale 1ns/1ps
`include "ooo_consts.svh"

module inst_decoder (
    input  logic              clk,
    input  logic              rst,
    input  logic              inst_valid,
    input  ooo_pkg::word_t    inst,
    input  ooo_pkg::word_t    rs_val,
    input  ooo_pkg::word_t    rt_val,
    input  logic              pred,
    input  logic              stall,
    input  logic              kill,
    output ooo_pkg::uop_t     alloc,
    output logic              alloc_valid,
    input  ooo_pkg::rob_tag_t alloc_tag,
    output ooo_pkg::issue_t   issue
);

    logic [5:0]        opcode;
    logic [5:0]        funct;
    ooo_pkg::op_t      op;
    ooo_pkg::reg_idx_t rd;
    logic              issue_valid;
    ooo_pkg::rob_tag_t issue_tag;
    ooo_pkg::uop_t     issue_uop;

    assign opcode = inst[31:26];
    assign funct  = inst[5:0];

    always_comb begin
        op = `OP_ILL;
        case (opcode)
            `OPC_RTYPE: begin
                case (funct)
                    `FN_ADD: op = `OP_ADD;
                    `FN_SUB: op = `OP_SUB;
                    `FN_AND: op = `OP_AND;
                    `FN_OR:  op = `OP_OR;
                    `FN_SLT: op = `OP_SLT;
                    default: op = `OP_ILL; // unsupported funct
                endcase
            end
            `OPC_LW:  op = `OP_LW;
            `OPC_SW:  op = `OP_SW;
            `OPC_BEQ: op = `OP_BEQ;
            `OPC_BNE: op = `OP_BNE;
            default:  op = `OP_ILL;
        endcase
    end

    // loads write rt, R-type ops write rd, the rest write nothing
    always_comb begin
        case (op)
            `OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_SLT: rd = inst[15:11];
            `OP_LW:  rd = inst[20:16];
            default: rd = '0;
        endcase
    end

    assign alloc = '{op: op, rd: rd, rs_val: rs_val, rt_val: rt_val,
                     imm: {{16{inst[15]}}, inst[15:0]}, pred: pred,
                     illegal: (op == `OP_ILL)};
    assign alloc_valid = inst_valid && !stall;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue_valid <= 1'b0;
        end else if (kill) begin
            issue_valid <= 1'b0; // the op in this register is younger than the head
        end else begin
            issue_valid <= alloc_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            issue_tag <= alloc_tag; // tag comes back from the buffer in the same cycle
            issue_uop <= alloc;
        end
    end

    assign issue = '{valid: issue_valid, tag: issue_tag, uop: issue_uop};

endmodule

//--- ooo_pkg.sv
package ooo_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  op_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  rob_idx_t;
    typedef logic [4:0]  rob_tag_t;     // buffer index plus one, zero means no tag

    // bit 2 register write, bit 1 memory read, bit 0 memory write
    typedef logic [2:0]  commit_ctrl_t;

    typedef struct packed {
        op_t      op;
        reg_idx_t rd;
        word_t    rs_val;
        word_t    rt_val;
        word_t    imm;      // already sign extended
        logic     pred;     // predicted taken
        logic     illegal;
    } uop_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        uop_t     uop;
    } issue_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    data;
        logic     taken;    // branch decision
        logic     ovf;      // signed overflow of add or sub
    } cdb_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    addr;
    } addr_bcast_t;

    typedef struct packed {
        op_t          op;
        reg_idx_t     rd;
        word_t        data;
        word_t        addr;
        commit_ctrl_t ctrl;
    } commit_t;

endpackage

//--- ooo_consts.svh
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

`define ROB_DEPTH 16

// internal operation codes carried by the micro-op
`define OP_ADD 4'd0
`define OP_SUB 4'd1
`define OP_AND 4'd2
`define OP_OR  4'd3
`define OP_SLT 4'd4
`define OP_LW  4'd5
`define OP_SW  4'd6
`define OP_BEQ 4'd7
`define OP_BNE 4'd8
`define OP_ILL 4'd15 // anything the decoder does not recognise

`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_OR  6'h25
`define FN_SLT 6'h2a

`define OPC_RTYPE 6'h00
`define OPC_LW    6'h23
`define OPC_SW    6'h2b
`define OPC_BEQ   6'h04
`define OPC_BNE   6'h05

`endif
